/* Makefile */
TOP = tb_exu

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* build.f */
src/exu_pkg.sv
src/exu_regfile.sv
src/exu_issue.sv
src/exu_int_unit.sv
src/exu_mul.sv
src/exu_wb.sv
src/exu_top.sv
verification/exu_props.sv
verification/tb_exu.sv

/* src/exu_int_unit.sv */
`timescale 1ns/1ns

module exu_int_unit import exu_pkg::*; #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            int_valid_e,
   input  alu_op_t         alu_op_e,
   input  bru_op_t         bru_op_e,
   input  logic [XLEN-1:0] a_e,
   input  logic [XLEN-1:0] b_e,
   input  logic [XLEN-1:0] pc_e,
   input  logic [XLEN-1:0] offs_e,
   input  reg_addr_t       rd_e,
   input  logic            wen_e,
   output logic            br_taken_e,
   output logic [XLEN-1:0] brpc_e,
   output logic            int_valid_r,
   output reg_addr_t       int_rd_r,
   output logic            int_wen_r,
   output logic [XLEN-1:0] int_res_r
);

   localparam int SHW = $clog2(XLEN);

   logic [SHW-1:0]  shamt;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] res_e;
   logic            cond;

   assign shamt = b_e[SHW-1:0];

   always_comb begin
      case (alu_op_e)
         ALU_ADD:  alu_res = a_e + b_e;
         ALU_SUB:  alu_res = a_e - b_e;
         ALU_AND:  alu_res = a_e & b_e;
         ALU_OR:   alu_res = a_e | b_e;
         ALU_XOR:  alu_res = a_e ^ b_e;
         ALU_SLT:  alu_res = XLEN'($signed(a_e) < $signed(b_e));
         ALU_SLTU: alu_res = XLEN'(a_e < b_e);
         ALU_SLL:  alu_res = a_e << shamt;
         ALU_SRL:  alu_res = a_e >> shamt;
         ALU_SRA:  alu_res = $unsigned($signed(a_e) >>> shamt);
         ALU_LUI:  alu_res = b_e;
         default:  alu_res = '0;
      endcase
   end

   always_comb begin
      case (bru_op_e)
         BRU_BEQ:  cond = (a_e == b_e);
         BRU_BNE:  cond = (a_e != b_e);
         BRU_BLT:  cond = ($signed(a_e) < $signed(b_e));
         BRU_BGE:  cond = ($signed(a_e) >= $signed(b_e));
         BRU_BLTU: cond = (a_e < b_e);
         BRU_BGEU: cond = (a_e >= b_e);
         BRU_JIRL: cond = 1'b1;
         default:  cond = 1'b0;   // plain ALU op
      endcase
   end

   assign br_taken_e = int_valid_e && cond;
   assign brpc_e     = (bru_op_e == BRU_JIRL) ? a_e + offs_e : pc_e + offs_e;

   // branches with a destination link pc + 4
   assign res_e = (bru_op_e != BRU_NONE) ? pc_e + XLEN'(4) : alu_res;

   always_ff @(posedge clk) begin
      if (rst) int_valid_r <= 1'b0;
      else     int_valid_r <= int_valid_e;
   end

   always_ff @(posedge clk) begin
      int_rd_r  <= rd_e;
      int_wen_r <= wen_e;
      int_res_r <= res_e;
   end

endmodule

/* src/exu_issue.sv */
`timescale 1ns/1ns

module exu_issue import exu_pkg::*; #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst,

   // decode stage
   input  logic            valid_d,
   input  exu_unit_t       unit_d,
   input  alu_op_t         alu_op_d,
   input  bru_op_t         bru_op_d,
   input  mul_op_t         mul_op_d,
   input  reg_addr_t       rs1_d,
   input  reg_addr_t       rs2_d,
   input  reg_addr_t       rd_d,
   input  logic            rf_wen_d,
   input  logic            use_imm_d,
   input  logic [XLEN-1:0] imm_d,
   input  logic [XLEN-1:0] pc_d,
   input  logic [XLEN-1:0] br_offs_d,
   input  logic [XLEN-1:0] rs1_data,
   input  logic [XLEN-1:0] rs2_data,
   output logic            stall_req,

   // execute stage registers
   output logic            int_valid_e,
   output logic            mul_valid_e,
   output alu_op_t         alu_op_e,
   output bru_op_t         bru_op_e,
   output mul_op_t         mul_op_e,
   output logic [XLEN-1:0] a_e,
   output logic [XLEN-1:0] b_e,
   output logic [XLEN-1:0] pc_e,
   output logic [XLEN-1:0] offs_e,
   output reg_addr_t       rd_e,
   output logic            wen_e,

   // multiply stage two
   input  reg_addr_t       mul_rd_m,
   input  logic            mul_wen_m
);

   logic ex_wr;      // execute stage will write rd_e
   logic m2_wr;      // multiply stage two will write mul_rd_m
   logic use_rs2;
   logic int_path_d;
   logic raw_rs1;
   logic raw_rs2;
   logic wb_clash;
   logic accept;

   assign int_path_d = (unit_d == UNIT_INT) || (unit_d == UNIT_BRU);
   assign use_rs2    = !use_imm_d || (unit_d == UNIT_BRU);

   assign ex_wr = (int_valid_e || mul_valid_e) && wen_e;
   assign m2_wr = mul_wen_m;   // only set while stage two holds a multiply

   always_comb begin
      raw_rs1 = (rs1_d != '0) &&
                ((ex_wr && rs1_d == rd_e) || (m2_wr && rs1_d == mul_rd_m));
      raw_rs2 = use_rs2 && (rs2_d != '0) &&
                ((ex_wr && rs2_d == rd_e) || (m2_wr && rs2_d == mul_rd_m));
   end

   // a writing int op issued now would retire with the multiply in execute
   assign wb_clash = int_path_d && rf_wen_d && mul_valid_e && wen_e;

   assign stall_req = valid_d && (raw_rs1 || raw_rs2 || wb_clash);
   assign accept    = valid_d && !stall_req;

   always_ff @(posedge clk) begin
      if (rst) begin
         int_valid_e <= 1'b0;
         mul_valid_e <= 1'b0;
      end else begin
         int_valid_e <= accept && int_path_d;
         mul_valid_e <= accept && (unit_d == UNIT_MUL);
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         alu_op_e <= alu_op_d;
         bru_op_e <= (unit_d == UNIT_BRU) ? bru_op_d : BRU_NONE;
         mul_op_e <= mul_op_d;
         a_e      <= rs1_data;
         // branches always compare against rs2
         b_e      <= (use_imm_d && unit_d != UNIT_BRU) ? imm_d : rs2_data;
         pc_e     <= pc_d;
         offs_e   <= br_offs_d;
         rd_e     <= rd_d;
         wen_e    <= rf_wen_d;
      end
   end

endmodule

/* src/exu_mul.sv */
`timescale 1ns/1ns

module exu_mul import exu_pkg::*; #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            mul_valid_e,
   input  mul_op_t         mul_op_e,
   input  logic [XLEN-1:0] a_e,
   input  logic [XLEN-1:0] b_e,
   input  reg_addr_t       rd_e,
   output logic            mul_valid_m,
   output reg_addr_t       mul_rd_m,
   output logic            mul_wen_m,
   output logic [XLEN-1:0] mul_res_m
);

   logic                      a_sx;   // extension bits set only for mulh_s
   logic                      b_sx;
   logic signed [XLEN:0]      a_ext;
   logic signed [XLEN:0]      b_ext;
   logic signed [2*XLEN+1:0]  prod_full;
   logic [2*XLEN-1:0]         prod_q;
   mul_op_t                   op_q;
   logic                      wen_q;

   // stage one
   assign a_sx      = (mul_op_e == MULH_S) && a_e[XLEN-1];
   assign b_sx      = (mul_op_e == MULH_S) && b_e[XLEN-1];
   assign a_ext     = {a_sx, a_e};
   assign b_ext     = {b_sx, b_e};
   assign prod_full = a_ext * b_ext;

   always_ff @(posedge clk) begin
      if (rst) mul_valid_m <= 1'b0;
      else     mul_valid_m <= mul_valid_e;
   end

   always_ff @(posedge clk) begin
      prod_q   <= prod_full[2*XLEN-1:0];
      op_q     <= mul_op_e;
      mul_rd_m <= rd_e;
      wen_q    <= (rd_e != '0);   // a multiply always has a destination
   end

   // stage two word select
   assign mul_wen_m = mul_valid_m && wen_q;
   assign mul_res_m = (op_q == MUL_LO) ? prod_q[XLEN-1:0] : prod_q[2*XLEN-1:XLEN];

endmodule

/* src/exu_pkg.sv */
package exu_pkg;

   // architectural register file size
   localparam int NUM_REGS = 32;
   localparam int REG_AW   = $clog2(NUM_REGS);

   typedef logic [REG_AW-1:0] reg_addr_t;   // r0 always reads zero

   // execution path of a decoded instruction
   typedef enum logic [1:0] {
      UNIT_NONE = 2'd0,
      UNIT_INT  = 2'd1,
      UNIT_BRU  = 2'd2,
      UNIT_MUL  = 2'd3
   } exu_unit_t;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SLT  = 4'd5,
      ALU_SLTU = 4'd6,
      ALU_SLL  = 4'd7,
      ALU_SRL  = 4'd8,
      ALU_SRA  = 4'd9,
      ALU_LUI  = 4'd10   // result is the immediate
   } alu_op_t;

   // BRU_NONE marks a plain ALU op on the integer path
   typedef enum logic [2:0] {
      BRU_NONE = 3'd0,
      BRU_BEQ  = 3'd1,
      BRU_BNE  = 3'd2,
      BRU_BLT  = 3'd3,
      BRU_BGE  = 3'd4,
      BRU_BLTU = 3'd5,
      BRU_BGEU = 3'd6,
      BRU_JIRL = 3'd7
   } bru_op_t;

   typedef enum logic [1:0] {
      MUL_LO = 2'd0,
      MULH_S = 2'd1,
      MULH_U = 2'd2
   } mul_op_t;

endpackage

/* src/exu_regfile.sv */
`timescale 1ns/1ns

module exu_regfile import exu_pkg::*; #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  reg_addr_t       rs1_addr,
   input  reg_addr_t       rs2_addr,
   output logic [XLEN-1:0] rs1_data,
   output logic [XLEN-1:0] rs2_data,
   input  logic            wen,
   input  reg_addr_t       waddr,
   input  logic [XLEN-1:0] wdata
);

   logic [XLEN-1:0] regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // write-through so a reader in the writeback cycle sees the new value
   always_comb begin
      if (rs1_addr == '0)                 rs1_data = '0;
      else if (wen && waddr == rs1_addr) rs1_data = wdata;
      else                                rs1_data = regs[rs1_addr];

      if (rs2_addr == '0)                 rs2_data = '0;
      else if (wen && waddr == rs2_addr) rs2_data = wdata;
      else                                rs2_data = regs[rs2_addr];
   end

endmodule

/* src/exu_top.sv */
`timescale 1ns/1ns

module exu_top import exu_pkg::*; #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst,

   input  logic            valid_d,
   input  exu_unit_t       unit_d,
   input  alu_op_t         alu_op_d,
   input  bru_op_t         bru_op_d,
   input  mul_op_t         mul_op_d,
   input  reg_addr_t       rs1_d,
   input  reg_addr_t       rs2_d,
   input  reg_addr_t       rd_d,
   input  logic            rf_wen_d,
   input  logic            use_imm_d,
   input  logic [XLEN-1:0] imm_d,
   input  logic [XLEN-1:0] pc_d,
   input  logic [XLEN-1:0] br_offs_d,
   output logic            stall_req,

   output logic            br_taken_e,
   output logic [XLEN-1:0] brpc_e,

   // retire port
   output logic            wb_valid,
   output reg_addr_t       wb_rd,
   output logic [XLEN-1:0] wb_data
);

   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;

   logic            int_valid_e;
   logic            mul_valid_e;
   alu_op_t         alu_op_e;
   bru_op_t         bru_op_e;
   mul_op_t         mul_op_e;
   logic [XLEN-1:0] a_e;
   logic [XLEN-1:0] b_e;
   logic [XLEN-1:0] pc_e;
   logic [XLEN-1:0] offs_e;
   reg_addr_t       rd_e;
   logic            wen_e;

   logic            int_valid_r;
   reg_addr_t       int_rd_r;
   logic            int_wen_r;
   logic [XLEN-1:0] int_res_r;

   logic            mul_valid_m;
   reg_addr_t       mul_rd_m;
   logic            mul_wen_m;
   logic [XLEN-1:0] mul_res_m;

   exu_regfile #(.XLEN(XLEN)) u_regfile (
      .clk       (clk        ),
      .rs1_addr  (rs1_d      ),
      .rs2_addr  (rs2_d      ),
      .rs1_data  (rs1_data   ),
      .rs2_data  (rs2_data   ),
      .wen       (wb_valid   ),
      .waddr     (wb_rd      ),
      .wdata     (wb_data    )
   );

   exu_issue #(.XLEN(XLEN)) u_issue (
      .clk         (clk         ),
      .rst         (rst         ),
      .valid_d     (valid_d     ),
      .unit_d      (unit_d      ),
      .alu_op_d    (alu_op_d    ),
      .bru_op_d    (bru_op_d    ),
      .mul_op_d    (mul_op_d    ),
      .rs1_d       (rs1_d       ),
      .rs2_d       (rs2_d       ),
      .rd_d        (rd_d        ),
      .rf_wen_d    (rf_wen_d    ),
      .use_imm_d   (use_imm_d   ),
      .imm_d       (imm_d       ),
      .pc_d        (pc_d        ),
      .br_offs_d   (br_offs_d   ),
      .rs1_data    (rs1_data    ),
      .rs2_data    (rs2_data    ),
      .stall_req   (stall_req   ),
      .int_valid_e (int_valid_e ),
      .mul_valid_e (mul_valid_e ),
      .alu_op_e    (alu_op_e    ),
      .bru_op_e    (bru_op_e    ),
      .mul_op_e    (mul_op_e    ),
      .a_e         (a_e         ),
      .b_e         (b_e         ),
      .pc_e        (pc_e        ),
      .offs_e      (offs_e      ),
      .rd_e        (rd_e        ),
      .wen_e       (wen_e       ),
      .mul_rd_m    (mul_rd_m    ),
      .mul_wen_m   (mul_wen_m   )
   );

   exu_int_unit #(.XLEN(XLEN)) u_int_unit (
      .clk         (clk         ),
      .rst         (rst         ),
      .int_valid_e (int_valid_e ),
      .alu_op_e    (alu_op_e    ),
      .bru_op_e    (bru_op_e    ),
      .a_e         (a_e         ),
      .b_e         (b_e         ),
      .pc_e        (pc_e        ),
      .offs_e      (offs_e      ),
      .rd_e        (rd_e        ),
      .wen_e       (wen_e       ),
      .br_taken_e  (br_taken_e  ),
      .brpc_e      (brpc_e      ),
      .int_valid_r (int_valid_r ),
      .int_rd_r    (int_rd_r    ),
      .int_wen_r   (int_wen_r   ),
      .int_res_r   (int_res_r   )
   );

   exu_mul #(.XLEN(XLEN)) u_mul (
      .clk         (clk         ),
      .rst         (rst         ),
      .mul_valid_e (mul_valid_e ),
      .mul_op_e    (mul_op_e    ),
      .a_e         (a_e         ),
      .b_e         (b_e         ),
      .rd_e        (rd_e        ),
      .mul_valid_m (mul_valid_m ),
      .mul_rd_m    (mul_rd_m    ),
      .mul_wen_m   (mul_wen_m   ),
      .mul_res_m   (mul_res_m   )
   );

   exu_wb #(.XLEN(XLEN)) u_wb (
      .clk         (clk         ),
      .rst         (rst         ),
      .int_valid_r (int_valid_r ),
      .int_rd_r    (int_rd_r    ),
      .int_wen_r   (int_wen_r   ),
      .int_res_r   (int_res_r   ),
      .mul_valid_m (mul_valid_m ),
      .mul_rd_m    (mul_rd_m    ),
      .mul_wen_m   (mul_wen_m   ),
      .mul_res_m   (mul_res_m   ),
      .wb_valid    (wb_valid    ),
      .wb_rd       (wb_rd       ),
      .wb_data     (wb_data     )
   );

endmodule

/* src/exu_wb.sv */
`timescale 1ns/1ns

module exu_wb import exu_pkg::*; #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            int_valid_r,
   input  reg_addr_t       int_rd_r,
   input  logic            int_wen_r,
   input  logic [XLEN-1:0] int_res_r,
   input  logic            mul_valid_m,
   input  reg_addr_t       mul_rd_m,
   input  logic            mul_wen_m,
   input  logic [XLEN-1:0] mul_res_m,
   output logic            wb_valid,
   output reg_addr_t       wb_rd,
   output logic [XLEN-1:0] wb_data
);

   logic            mul_wr_w;   // multiply retiring this cycle
   reg_addr_t       mul_rd_w;
   logic [XLEN-1:0] mul_res_w;
   logic            int_wr;

   always_ff @(posedge clk) begin
      if (rst) mul_wr_w <= 1'b0;
      else     mul_wr_w <= mul_valid_m && mul_wen_m;
   end

   always_ff @(posedge clk) begin
      mul_rd_w  <= mul_rd_m;
      mul_res_w <= mul_res_m;
   end

   assign int_wr = int_valid_r && int_wen_r;

   // issue keeps the two writers apart
   assign wb_rd    = mul_wr_w ? mul_rd_w : int_rd_r;
   assign wb_data  = mul_wr_w ? mul_res_w : int_res_r;
   assign wb_valid = (mul_wr_w || int_wr) && (wb_rd != '0);

endmodule

/* verification/exu_props.sv */
`timescale 1ns/1ns

module exu_props (
   input logic clk,
   input logic rst,
   input logic valid_d,
   input logic stall_req,
   input logic int_valid_e,
   input logic mul_valid_e
);

   // each issued instruction takes exactly one path
   a_one_path : assert property (@(posedge clk) disable iff (rst)
      !(int_valid_e && mul_valid_e))
      else $error("int and mul paths both valid in execute");

   a_hold_on_stall : assert property (@(posedge clk) disable iff (rst)
      (valid_d && stall_req) |=> !(int_valid_e || mul_valid_e))
      else $error("instruction issued while stall_req was high");

   a_reset_clear : assert property (@(posedge clk)
      rst |=> !(int_valid_e || mul_valid_e))   // valids low right after reset
      else $error("execute valids not cleared by reset");

endmodule

bind exu_issue exu_props i_props (
   .clk         (clk),
   .rst         (rst),
   .valid_d     (valid_d),
   .stall_req   (stall_req),
   .int_valid_e (int_valid_e),
   .mul_valid_e (mul_valid_e)
);

/* verification/tb_exu.sv */
`timescale 1ns/1ns

module tb_exu import exu_pkg::*; ();

   localparam int          XLEN         = 32;
   localparam int          RESET_CYCLES = 8;
   localparam logic [31:0] SEED         = 32'h363ee4db;

   // one decoded instruction as the front end presents it
   typedef struct packed {
      exu_unit_t       unit;
      logic [3:0]      op;     // alu, bru or mul code by unit
      reg_addr_t       rd;
      reg_addr_t       rs1;
      reg_addr_t       rs2;
      logic            wen;
      logic            use_imm;
      logic [XLEN-1:0] imm;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] offs;
   } row_t;

   logic            clk;
   logic            rst;
   logic            valid_d;
   exu_unit_t       unit_d;
   alu_op_t         alu_op_d;
   bru_op_t         bru_op_d;
   mul_op_t         mul_op_d;
   reg_addr_t       rs1_d;
   reg_addr_t       rs2_d;
   reg_addr_t       rd_d;
   logic            rf_wen_d;
   logic            use_imm_d;
   logic [XLEN-1:0] imm_d;
   logic [XLEN-1:0] pc_d;
   logic [XLEN-1:0] br_offs_d;
   logic            stall_req;
   logic            br_taken_e;
   logic [XLEN-1:0] brpc_e;
   logic            wb_valid;
   reg_addr_t       wb_rd;
   logic [XLEN-1:0] wb_data;

   row_t            prog[$];
   logic [XLEN-1:0] model_regs [NUM_REGS];
   reg_addr_t       exp_rd[$];      // expected writebacks in program order
   logic [XLEN-1:0] exp_data[$];
   logic            br_pending;
   logic            exp_taken;
   logic [XLEN-1:0] exp_target;
   int              value_errs   = 0;
   int              extra_errs   = 0;
   int              missing_errs = 0;
   int              cycles       = 0;
   int              limit        = 1000;

   exu_top #(.XLEN(XLEN)) i_exu_top (.*);

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout, run stopped after %0d cycles", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   function automatic logic [XLEN-1:0] alu_ref(alu_op_t op, logic [XLEN-1:0] a,
                                               logic [XLEN-1:0] b);
      logic [$clog2(XLEN)-1:0] sh;
      logic [XLEN-1:0]         msb;
      logic [2*XLEN-1:0]       ext;
      logic [XLEN-1:0]         res;
      sh  = b[$clog2(XLEN)-1:0];
      msb = XLEN'(1) << (XLEN - 1);
      ext = {{XLEN{a[XLEN-1]}}, a} >> sh;   // arithmetic shift via sign extension
      case (op)
         ALU_ADD:  res = a + b;
         ALU_SUB:  res = a + ~b + XLEN'(1);
         ALU_AND:  res = a & b;
         ALU_OR:   res = a | b;
         ALU_XOR:  res = a ^ b;
         ALU_SLT:  res = {{(XLEN-1){1'b0}}, (a ^ msb) < (b ^ msb)};
         ALU_SLTU: res = {{(XLEN-1){1'b0}}, a < b};
         ALU_SLL:  res = a << sh;
         ALU_SRL:  res = a >> sh;
         ALU_SRA:  res = ext[XLEN-1:0];
         ALU_LUI:  res = b;
         default:  res = '0;
      endcase
      return res;
   endfunction

   function automatic logic [XLEN-1:0] mul_ref(mul_op_t op, logic [XLEN-1:0] a,
                                               logic [XLEN-1:0] b);
      logic [2*XLEN-1:0] p;
      if (op == MULH_S)
         p = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
      else
         p = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
      return (op == MUL_LO) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
   endfunction

   function automatic logic br_ref(bru_op_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
      logic lt_u;
      logic lt_s;
      lt_u = a < b;
      lt_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : lt_u;   // sign bit decides if signs differ
      case (op)
         BRU_BEQ:  return a == b;
         BRU_BNE:  return a != b;
         BRU_BLT:  return lt_s;
         BRU_BGE:  return !lt_s;
         BRU_BLTU: return lt_u;
         BRU_BGEU: return !lt_u;
         BRU_JIRL: return 1'b1;
         default:  return 1'b0;
      endcase
   endfunction

   task automatic add_row(exu_unit_t unit, logic [3:0] op, reg_addr_t rd, reg_addr_t rs1,
                          reg_addr_t rs2, logic use_imm, logic [XLEN-1:0] imm,
                          logic [XLEN-1:0] pc, logic [XLEN-1:0] offs);
      // conditional branches write nothing
      prog.push_back('{unit, op, rd, rs1, rs2, unit != UNIT_BRU || op == 4'(BRU_JIRL),
                       use_imm, imm, pc, offs});
   endtask

   task automatic build_table();
      reg_addr_t pa [4];
      reg_addr_t pb [4];
      pa = '{5'd1, 5'd9, 5'd11, 5'd9};
      pb = '{5'd2, 5'd11, 5'd11, 5'd10};
      foreach (model_regs[i])
         model_regs[i] = '0;
      for (int i = 0; i < 8; i++)   // random operands in r1..r8
         add_row(UNIT_INT, ALU_LUI, 5'(i + 1), '0, '0, 1'b1, $urandom(), '0, '0);
      add_row(UNIT_INT, ALU_LUI, 5'd9, '0, '0, 1'b1, 32'h8000_0000, '0, '0);
      add_row(UNIT_INT, ALU_LUI, 5'd10, '0, '0, 1'b1, 32'h7fff_ffff, '0, '0);
      add_row(UNIT_INT, ALU_LUI, 5'd11, '0, '0, 1'b1, 32'hffff_ffff, '0, '0);
      add_row(UNIT_INT, ALU_LUI, 5'd12, '0, '0, 1'b1, 32'd5, '0, '0);
      add_row(UNIT_INT, ALU_ADD, 5'd13, 5'd1, 5'd0, 1'b0, '0, '0, '0);   // copy of r1
      for (int i = 0; i < 10; i++) begin
         add_row(UNIT_INT, 4'(i), 5'(14 + i), 5'd1, 5'd2, 1'b0, '0, '0, '0);
         add_row(UNIT_INT, 4'(i), 5'(24 + i % 6), 5'd3, 5'd0, 1'b1, $urandom(), '0, '0);
      end
      add_row(UNIT_INT, ALU_ADD, 5'd0, 5'd1, 5'd2, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_SLT, 5'd30, 5'd9, 5'd10, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_SLTU, 5'd30, 5'd9, 5'd10, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_SRA, 5'd31, 5'd9, 5'd12, 1'b0, '0, '0, '0);
      for (int j = 0; j < 4; j++) begin
         for (int i = 0; i < 3; i++)   // back to back without dependences
            add_row(UNIT_MUL, 4'(i), 5'(26 + (3 * j + i) % 5), pa[j], pb[j], 1'b0, '0, '0, '0);
      end
      add_row(UNIT_MUL, 4'(MUL_LO), 5'd0, 5'd1, 5'd2, 1'b0, '0, '0, '0);
      // equal, signed less, signed greater, both less
      pb = '{5'd13, 5'd10, 5'd9, 5'd10};
      pa = '{5'd1, 5'd9, 5'd10, 5'd12};
      for (int j = 0; j < 4; j++) begin
         for (int i = 1; i < 7; i++)
            add_row(UNIT_BRU, 4'(i), '0, pa[j], pb[j], 1'b0, '0,
                    32'h1000 + 32'(64 * j + 4 * i), $urandom() & 32'hffff_fffc);
      end
      add_row(UNIT_BRU, 4'(BRU_JIRL), 5'd29, 5'd3, '0, 1'b0, '0, 32'h2000, 32'h100);
      // dependence chains across both paths
      add_row(UNIT_INT, ALU_ADD, 5'd5, 5'd1, 5'd2, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_ADD, 5'd6, 5'd5, 5'd1, 1'b0, '0, '0, '0);
      add_row(UNIT_MUL, 4'(MUL_LO), 5'd7, 5'd6, 5'd2, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_SUB, 5'd8, 5'd7, 5'd1, 1'b0, '0, '0, '0);
      add_row(UNIT_MUL, 4'(MUL_LO), 5'd5, 5'd8, 5'd8, 1'b0, '0, '0, '0);
      add_row(UNIT_MUL, 4'(MULH_U), 5'd6, 5'd5, 5'd1, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_OR, 5'd4, 5'd6, 5'd0, 1'b1, 32'h0000_00ff, '0, '0);
      add_row(UNIT_BRU, 4'(BRU_JIRL), 5'd28, 5'd4, '0, 1'b0, '0, 32'h3000, 32'h20);
      // integer ops right behind multiplies
      add_row(UNIT_MUL, 4'(MUL_LO), 5'd20, 5'd1, 5'd2, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_ADD, 5'd21, 5'd3, 5'd0, 1'b1, 32'h10, '0, '0);
      add_row(UNIT_MUL, 4'(MULH_S), 5'd22, 5'd9, 5'd2, 1'b0, '0, '0, '0);
      add_row(UNIT_BRU, 4'(BRU_BNE), '0, 5'd1, 5'd2, 1'b0, '0, 32'h4000, 32'h80);
      add_row(UNIT_MUL, 4'(MUL_LO), 5'd23, 5'd1, 5'd1, 1'b0, '0, '0, '0);
      add_row(UNIT_INT, ALU_SUB, 5'd23, 5'd2, 5'd3, 1'b0, '0, '0, '0);   // same rd as mul
   endtask

   task automatic idle_inputs();
      valid_d   = 1'b0;
      unit_d    = UNIT_NONE;
      alu_op_d  = ALU_ADD;
      bru_op_d  = BRU_NONE;
      mul_op_d  = MUL_LO;
      rs1_d     = '0;
      rs2_d     = '0;
      rd_d      = '0;
      rf_wen_d  = 1'b0;
      use_imm_d = 1'b0;
      imm_d     = '0;
      pc_d      = '0;
      br_offs_d = '0;
   endtask

   task automatic drive_row(row_t r);
      valid_d   = 1'b1;
      unit_d    = r.unit;
      alu_op_d  = alu_op_t'(r.op);
      bru_op_d  = bru_op_t'(r.op[2:0]);
      mul_op_d  = mul_op_t'(r.op[1:0]);
      rs1_d     = r.rs1;
      rs2_d     = r.rs2;
      rd_d      = r.rd;
      rf_wen_d  = r.wen;
      use_imm_d = r.use_imm;
      imm_d     = r.imm;
      pc_d      = r.pc;
      br_offs_d = r.offs;
   endtask

   // model of one accepted instruction in program order
   task automatic accept_row(row_t r);
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] rs2v;
      logic [XLEN-1:0] b;
      logic [XLEN-1:0] res;
      a    = model_regs[r.rs1];
      rs2v = model_regs[r.rs2];
      b    = (r.use_imm && r.unit != UNIT_BRU) ? r.imm : rs2v;
      res  = '0;
      case (r.unit)
         UNIT_INT: res = alu_ref(alu_op_t'(r.op), a, b);
         UNIT_MUL: res = mul_ref(mul_op_t'(r.op[1:0]), a, b);
         UNIT_BRU: begin
            br_pending = 1'b1;
            exp_taken  = br_ref(bru_op_t'(r.op[2:0]), a, rs2v);
            exp_target = ((r.op == 4'(BRU_JIRL)) ? a : r.pc) + r.offs;
            res        = r.pc + XLEN'(4);   // link value
         end
         default: res = '0;
      endcase
      if (r.wen && r.rd != '0) begin
         model_regs[r.rd] = res;
         exp_rd.push_back(r.rd);
         exp_data.push_back(res);
      end
   endtask

   task automatic check_wb(reg_addr_t rd, logic [XLEN-1:0] data);
      reg_addr_t       want_rd;
      logic [XLEN-1:0] want_data;
      if (exp_rd.size() == 0) begin
         extra_errs++;
         $display("extra writeback to r%0d with %h while none was pending", rd, data);
      end else begin
         want_rd   = exp_rd.pop_front();
         want_data = exp_data.pop_front();
         if (rd !== want_rd || data !== want_data) begin
            value_errs++;
            $display("[FAIL] %0t: writeback r%0d = %h, expected r%0d = %h",
                     $time, rd, data, want_rd, want_data);
         end
      end
   endtask

   task automatic check_branch(logic taken, logic [XLEN-1:0] target);
      if (taken !== exp_taken || target !== exp_target) begin
         value_errs++;
         $display("[FAIL] %0t: branch taken %b target %h, expected taken %b target %h",
                  $time, taken, target, exp_taken, exp_target);
      end
   endtask

   task automatic check_idle();
      if (stall_req !== 1'b0 || wb_valid !== 1'b0 || br_taken_e !== 1'b0) begin
         value_errs++;
         $display("[FAIL] %0t: after reset stall_req %b wb_valid %b br_taken_e %b, expected 0",
                  $time, stall_req, wb_valid, br_taken_e);
      end
   endtask

   // runs in the cycle after each acceptance
   task automatic check_execute();
      if (br_pending) begin
         check_branch(br_taken_e, brpc_e);
      end else if (br_taken_e !== 1'b0) begin
         value_errs++;
         $display("[FAIL] %0t: br_taken_e %b with no branch in execute", $time, br_taken_e);
      end
      br_pending = 1'b0;
   endtask

   always @(negedge clk) begin
      if (!rst && wb_valid)
         check_wb(wb_rd, wb_data);
   end

   initial begin
      int idx;
      clk        = 1'b0;
      rst        = 1'b1;
      br_pending = 1'b0;
      exp_taken  = 1'b0;
      exp_target = '0;
      idle_inputs();
      void'($urandom(SEED));
      build_table();
      limit = 4 * prog.size() + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst = 1'b0;
      @(negedge clk);
      check_idle();

      idx = 0;
      while (idx < prog.size()) begin
         @(posedge clk);
         #1;
         drive_row(prog[idx]);   // same values again while stalled
         @(negedge clk);
         check_execute();
         if (!stall_req) begin
            accept_row(prog[idx]);
            idx++;
         end
      end
      @(posedge clk);
      #1;
      idle_inputs();
      @(negedge clk);
      check_execute();
      repeat (5) @(negedge clk);   // longest path is three cycles

      if (exp_rd.size() != 0) begin
         missing_errs = exp_rd.size();
         $display("%0d expected writebacks never appeared, first one for r%0d",
                  missing_errs, exp_rd[0]);
      end
      $display("errors: %0d wrong values, %0d extra writebacks, %0d missing writebacks",
               value_errs, extra_errs, missing_errs);
      if (value_errs + extra_errs + missing_errs == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
